/* Bender.yml */
package:
  name: acq

sources:
  - source/acq_pkg.sv
  - source/adc_spi_reader.sv
  - source/peak_cache.sv
  - source/level_trigger.sv
  - source/ring_buffer.sv
  - source/command_reader.sv
  - source/acq_top.sv
  - target: test
    files:
      - bench/acq_asserts.sv
      - bench/acq_tb.sv

/* bench/acq_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_asserts (
    input logic clk,
    input logic reset_b,
    input logic sclk,
    input logic cs,
    input logic tx_en,
    input logic tx_ready
);

    // count of failed assertions
    int fail_count = 0;

    // serial clock parked low between frames
    property sclk_parked_p;
        @(posedge clk) disable iff (!reset_b) cs |-> !sclk;
    endproperty

    // transmitter must be ready when a byte goes out
    property tx_when_ready_p;
        @(posedge clk) disable iff (!reset_b) tx_en |-> tx_ready;
    endproperty

    // strobe is a single cycle
    property tx_single_p;
        @(posedge clk) disable iff (!reset_b) tx_en |=> !tx_en;
    endproperty

    sclk_parked_a: assert property (sclk_parked_p)
        else begin
            fail_count++;
            $error("sclk high while cs is high");
        end
    tx_when_ready_a: assert property (tx_when_ready_p)
        else begin
            fail_count++;
            $error("tx_en asserted while tx_ready is low");
        end
    tx_single_a: assert property (tx_single_p)
        else begin
            fail_count++;
            $error("tx_en high for two cycles in a row");
        end

endmodule

bind acq_top acq_asserts u_asserts (
    .clk      (clk),
    .reset_b  (reset_b),
    .sclk     (sclk),
    .cs       (cs),
    .tx_en    (tx_en),
    .tx_ready (tx_ready)
);

`default_nettype wire

/* bench/acq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_tb;
    import acq_pkg::*;

    localparam int CLK_DIV    = 2;
    localparam int DEPTH      = 64;
    localparam int POST       = 32;
    localparam int NUM_TESTS  = 15;
    // one frame is 12 serial periods, plus some margin
    localparam int FRAME_WAIT = 24 * CLK_DIV + 12;
    localparam int LOG_LEN    = 512;

    typedef enum logic [2:0] {rep_none, rep_status, rep_err, rep_peak, rep_dump} reply_kind_t;

    // command bytes left aligned with the first byte on top
    typedef struct packed {
        logic [23:0] cmd;
        logic [1:0]  n_cmd;
        logic [15:0] cycles;
        logic        ramp;
        reply_kind_t kind;
        byte_t       exp;
    } entry_t;

    logic                clk;
    logic                reset_b;
    logic [CHANNELS-1:0] sdata;
    logic                sclk;
    logic                cs;
    byte_t               rx_data;
    logic                rx_ready;
    byte_t               tx_data;
    logic                tx_en;
    logic                tx_ready;
    logic                triggered;
    logic                frozen;

    entry_t      tests [NUM_TESTS];
    byte_t       reply_q [$];
    byte_t       expect_q [$];
    // every completed adc frame per channel
    sample_t     log_mem [CHANNELS][LOG_LEN];
    int          n_frames;
    // first frame not yet covered by a peak read
    int          peak_base [CHANNELS];
    int          arm_idx;
    sample_t     thresh;
    int          errors;
    logic [31:0] rng_state;
    logic        ramp_mode;
    sample_t     ramp_val;
    sample_t     adc_word [CHANNELS];
    int          bit_idx;
    logic        frame_on;

    acq_top #(
        .CLK_DIV (CLK_DIV),
        .DEPTH   (DEPTH),
        .POST    (POST)
    ) DUT (
        .clk       (clk),
        .reset_b   (reset_b),
        .sdata     (sdata),
        .sclk      (sclk),
        .cs        (cs),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .tx_data   (tx_data),
        .tx_en     (tx_en),
        .tx_ready  (tx_ready),
        .triggered (triggered),
        .frozen    (frozen)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic entry_t make_entry(input logic [23:0] cmd, input int n, input int cyc,
                                          input logic ramp, input reply_kind_t kind,
                                          input byte_t exp);
        entry_t e;
        e.cmd    = cmd;
        e.n_cmd  = 2'(n);
        e.cycles = 16'(cyc);
        e.ramp   = ramp;
        e.kind   = kind;
        e.exp    = exp;
        return e;
    endfunction

    function automatic int reply_len(input reply_kind_t k);
        case (k)
            rep_status, rep_err: return 1;
            rep_peak: return 2;
            rep_dump: return 2 * DEPTH + 1;
            default: return 0;
        endcase
    endfunction

    // status nibble bits from msb are sampling armed triggered and frozen
    task automatic load_table();
        tests[0]  = make_entry({OP_STATUS, 16'h0}, 1, 0, 1'b0, rep_status, 8'h00);
        tests[1]  = make_entry({OP_DUMP, 16'h0}, 1, 0, 1'b0, rep_err, 8'h00);
        tests[2]  = make_entry({8'h10, 16'h0}, 1, 1500, 1'b0, rep_peak, 8'h00);
        tests[3]  = make_entry({8'h11, 16'h0}, 1, 0, 1'b0, rep_peak, 8'h00);
        tests[4]  = make_entry({8'h12, 16'h0}, 1, 0, 1'b0, rep_peak, 8'h00);
        tests[5]  = make_entry({8'h13, 16'h0}, 1, 0, 1'b0, rep_peak, 8'h00);
        tests[6]  = make_entry({8'h10, 16'h0}, 1, 0, 1'b0, rep_peak, 8'h00);
        tests[7]  = make_entry({OP_THRESH, 16'h0180}, 3, 0, 1'b0, rep_none, 8'h00);
        tests[8]  = make_entry({OP_STATUS, 16'h0}, 1, 0, 1'b0, rep_status, 8'h04);
        // ramp crosses 0x180 and runs well past POST frames
        tests[9]  = make_entry({OP_STATUS, 16'h0}, 1, 4000, 1'b1, rep_status, 8'h03);
        tests[10] = make_entry({OP_DUMP, 16'h0}, 1, 0, 1'b0, rep_dump, 8'h00);
        tests[11] = make_entry({8'h77, 16'h0}, 1, 0, 1'b0, rep_err, 8'h00);
        tests[12] = make_entry({8'h15, 16'h0}, 1, 0, 1'b0, rep_err, 8'h00);
        tests[13] = make_entry({OP_THRESH, 16'h03FF}, 3, 0, 1'b0, rep_none, 8'h00);
        tests[14] = make_entry({OP_STATUS, 16'h0}, 1, 0, 1'b0, rep_status, 8'h04);
    endtask

    // adc model loads a new word per channel when cs falls and sends it msb first
    always @(negedge cs) begin
        for (int i = 0; i < CHANNELS; i++) begin
            rng_state   = lcg_next(rng_state);
            adc_word[i] = (ramp_mode && i == 0) ? ramp_val : rng_state[25:16];
        end
        if (ramp_mode) begin
            ramp_val = ramp_val + 10'd4;
        end
        frame_on = 1'b1;
        bit_idx  = 9;
        #1;
        for (int i = 0; i < CHANNELS; i++) begin
            sdata[i] = adc_word[i][9];
        end
    end

    // next bit after each falling sclk edge
    always @(negedge sclk) begin
        #1;
        if (frame_on && bit_idx > 0) begin
            bit_idx = bit_idx - 1;
            for (int i = 0; i < CHANNELS; i++) begin
                sdata[i] = adc_word[i][bit_idx];
            end
        end
    end

    // cs rising closes a complete frame
    always @(posedge cs) begin
        if (frame_on) begin
            for (int i = 0; i < CHANNELS; i++) begin
                log_mem[i][n_frames] = adc_word[i];
            end
            n_frames = n_frames + 1;
            frame_on = 1'b0;
        end
    end

    // transmitter model stays busy for 6 cycles after each byte
    always @(negedge clk) begin
        if (tx_en === 1'b1) begin
            reply_q.push_back(tx_data);
            @(posedge clk);
            #1 tx_ready = 1'b0;
            repeat (6) @(posedge clk);
            #1 tx_ready = 1'b1;
        end
    end

    task automatic send_byte(input byte_t b);
        @(posedge clk);
        #1;
        rx_data  = b;
        rx_ready = 1'b1;
        @(posedge clk);
        #1;
        rx_ready = 1'b0;
    endtask

    // high byte carries the top 2 bits
    task automatic push_sample(input sample_t w);
        expect_q.push_back({6'b0, w[9:8]});
        expect_q.push_back(w[7:0]);
    endtask

    task automatic build_expected(input int t, input entry_t e);
        chan_t   ch;
        sample_t pk;
        int      k;
        expect_q.delete();
        case (e.kind)
            rep_status: expect_q.push_back(e.exp);
            rep_err: expect_q.push_back(REPLY_ERR);
            rep_peak: begin
                ch = chan_t'(e.cmd[19:16]);
                pk = '0;
                for (int f = peak_base[ch]; f < n_frames; f++) begin
                    if (log_mem[ch][f] > pk) begin
                        pk = log_mem[ch][f];
                    end
                end
                // read clears the peak
                peak_base[ch] = n_frames;
                push_sample(pk);
            end
            rep_dump: begin
                k = -1;
                for (int f = arm_idx; f < n_frames && k < 0; f++) begin
                    if (log_mem[0][f] > thresh) begin
                        k = f;
                    end
                end
                if (k < 0 || k + POST >= n_frames || k + POST < DEPTH - 1) begin
                    $display("entry %0d: frame log holds no usable trigger point", t);
                    errors++;
                end else begin
                    expect_q.push_back(REPLY_DUMP_HEAD);
                    // DEPTH newest samples up to the freeze in oldest first order
                    for (int f = k + POST - DEPTH + 1; f <= k + POST; f++) begin
                        push_sample(log_mem[0][f]);
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic run_entry(input int t);
        entry_t e;
        int     waited;
        e = tests[t];
        if (e.cycles != 0) begin
            ramp_mode = e.ramp;
            send_byte(OP_START);
            repeat (e.cycles) @(posedge clk);
            send_byte(OP_STOP);
            repeat (FRAME_WAIT) @(posedge clk);
        end
        reply_q.delete();
        build_expected(t, e);
        for (int b = 0; b < e.n_cmd; b++) begin
            send_byte(e.cmd[23 - 8 * b -: 8]);
        end
        // arm point and threshold for the dump window
        if (e.cmd[23:16] == OP_THRESH) begin
            arm_idx = n_frames;
            thresh  = sample_t'({e.cmd[9:8], e.cmd[7:0]});
        end
        waited = 0;
        while (reply_q.size() < expect_q.size() && waited < 400 * expect_q.size()) begin
            @(posedge clk);
            waited++;
        end
        // room for stray bytes
        repeat (20) @(posedge clk);
        #1;
        if (reply_q.size() != expect_q.size()) begin
            $display("entry %0d: reply has %0d bytes, %0d were expected", t,
                     reply_q.size(), expect_q.size());
            errors++;
        end
        for (int b = 0; b < expect_q.size() && b < reply_q.size(); b++) begin
            if (reply_q[b] !== expect_q[b]) begin
                $display("** Error @ %0t: entry %0d byte %0d expected %02h got %02h",
                         $time, t, b, expect_q[b], reply_q[b]);
                errors++;
            end
        end
        if (e.kind == rep_status && (triggered !== e.exp[1] || frozen !== e.exp[0])) begin
            $display("** Error @ %0t: entry %0d ports expected triggered %b frozen %b got %b %b",
                     $time, t, e.exp[1], e.exp[0], triggered, frozen);
            errors++;
        end
    endtask

    initial begin
        load_table();
        reset_b   = 1'b0;
        sdata     = '0;
        rx_data   = '0;
        rx_ready  = 1'b0;
        tx_ready  = 1'b1;
        rng_state = 32'd93725;
        ramp_mode = 1'b0;
        ramp_val  = 10'h100;
        frame_on  = 1'b0;
        bit_idx   = 0;
        n_frames  = 0;
        arm_idx   = 0;
        thresh    = '0;
        errors    = 0;
        for (int i = 0; i < CHANNELS; i++) begin
            peak_base[i] = 0;
        end
        repeat (4) @(posedge clk);
        #1 reset_b = 1'b1;
        repeat (5) @(posedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        $display("run complete, %0d check errors, %0d assertion failures", errors,
                 DUT.u_asserts.fail_count);
        if (errors == 0 && DUT.u_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // budget grows with sampling time and reply length
    initial begin
        int budget;
        @(posedge reset_b);
        budget = 500;
        for (int t = 0; t < NUM_TESTS; t++) begin
            budget += tests[t].cycles + 400 * reply_len(tests[t].kind) + 300;
        end
        repeat (budget) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", budget);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/acq_pkg.sv
source/adc_spi_reader.sv
source/peak_cache.sv
source/level_trigger.sv
source/ring_buffer.sv
source/command_reader.sv
source/acq_top.sv
bench/acq_asserts.sv
bench/acq_tb.sv

/* source/acq_pkg.sv */
`default_nettype none

package acq_pkg;

    // four adcs share one sclk and one cs
    localparam int CHANNELS = 4;

    typedef logic [9:0] sample_t;
    typedef logic [1:0] chan_t;
    typedef logic [7:0] byte_t;

    // one frame of all channels, captured together
    typedef struct packed {
        sample_t [CHANNELS-1:0] ch;
    } sample_set_t;

    // arm is a single cycle pulse
    typedef struct packed {
        sample_t threshold;
        logic    arm;
    } trig_cfg_t;

    // sent in the low nibble of the status reply
    typedef struct packed {
        logic sampling;
        logic armed;
        logic triggered;
        logic frozen;
    } status_t;

    // low nibble of OP_PEAK carries the channel
    localparam byte_t OP_PEAK   = 8'h10;
    localparam byte_t OP_THRESH = 8'h30;
    localparam byte_t OP_DUMP   = 8'h40;
    localparam byte_t OP_STATUS = 8'h50;
    localparam byte_t OP_STOP   = 8'h60;
    localparam byte_t OP_START  = 8'h61;

    localparam byte_t REPLY_DUMP_HEAD = 8'h55;
    localparam byte_t REPLY_ERR       = 8'hEE;

endpackage

`default_nettype wire

/* source/acq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_top #(
    parameter int CLK_DIV = 4,
    parameter int DEPTH   = 64,
    parameter int POST    = 32
) (
    input  logic                          clk,
    input  logic                          reset_b,
    input  logic [acq_pkg::CHANNELS-1:0]  sdata,
    output logic                          sclk,
    output logic                          cs,
    input  acq_pkg::byte_t                rx_data,
    input  logic                          rx_ready,
    output acq_pkg::byte_t                tx_data,
    output logic                          tx_en,
    input  logic                          tx_ready,
    output logic                          triggered,
    output logic                          frozen
);
    import acq_pkg::*;

    logic        sample_en;
    sample_set_t samples;
    logic        sample_valid;
    chan_t       peak_sel;
    logic        peak_clear;
    sample_t     peak_value;
    trig_cfg_t   trig_cfg;
    logic        trigger;
    logic        armed;
    logic        rd_req;
    sample_t     rd_data;
    status_t     status;

    // status nibble seen by the host
    assign status = '{sampling: sample_en, armed: armed, triggered: triggered, frozen: frozen};

    adc_spi_reader #(
        .CLK_DIV (CLK_DIV)
    ) u_spi (
        .clk          (clk),
        .reset_b      (reset_b),
        .sample_en    (sample_en),
        .sdata        (sdata),
        .sclk         (sclk),
        .cs           (cs),
        .samples      (samples),
        .sample_valid (sample_valid)
    );

    peak_cache u_peak (
        .clk          (clk),
        .reset_b      (reset_b),
        .samples      (samples),
        .sample_valid (sample_valid),
        .peak_sel     (peak_sel),
        .peak_clear   (peak_clear),
        .peak_value   (peak_value)
    );

    level_trigger u_trig (
        .clk          (clk),
        .reset_b      (reset_b),
        .samples      (samples),
        .sample_valid (sample_valid),
        .trig_cfg     (trig_cfg),
        .trigger      (trigger),
        .armed        (armed),
        .triggered    (triggered)
    );

    // arm also restarts the capture
    ring_buffer #(
        .DEPTH (DEPTH),
        .POST  (POST)
    ) u_ring (
        .clk          (clk),
        .reset_b      (reset_b),
        .samples      (samples),
        .sample_valid (sample_valid),
        .trigger      (trigger),
        .arm          (trig_cfg.arm),
        .rd_req       (rd_req),
        .frozen       (frozen),
        .rd_data      (rd_data)
    );

    command_reader #(
        .DEPTH (DEPTH)
    ) u_cmd (
        .clk        (clk),
        .reset_b    (reset_b),
        .rx_data    (rx_data),
        .rx_ready   (rx_ready),
        .tx_ready   (tx_ready),
        .peak_value (peak_value),
        .rd_data    (rd_data),
        .status     (status),
        .tx_data    (tx_data),
        .tx_en      (tx_en),
        .sample_en  (sample_en),
        .peak_sel   (peak_sel),
        .peak_clear (peak_clear),
        .trig_cfg   (trig_cfg),
        .rd_req     (rd_req)
    );

endmodule

`default_nettype wire

/* source/adc_spi_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi_reader #(
    parameter int CLK_DIV = 4
) (
    input  logic                           clk,
    input  logic                           reset_b,
    input  logic                           sample_en,
    input  logic [acq_pkg::CHANNELS-1:0]   sdata,
    output logic                           sclk,
    output logic                           cs,
    output acq_pkg::sample_set_t           samples,
    output logic                           sample_valid
);
    import acq_pkg::*;

    localparam int DIV_W = $clog2(CLK_DIV + 1);

    typedef enum logic [1:0] {idle, shift, gap} spi_state_t;

    spi_state_t       state_q;
    logic [DIV_W-1:0] div_cnt;
    // bit count while shifting, half periods while in the gap
    logic [3:0]       cnt_q;
    logic             tick;
    logic             shift_en;
    sample_set_t      shift_q;

    // one tick per half serial clock period
    assign tick     = (div_cnt == DIV_W'(CLK_DIV - 1));
    // rising sclk edge, adc bit is stable here
    assign shift_en = (state_q == shift) && tick && !sclk;
    assign samples  = shift_q;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state_q      <= idle;
            div_cnt      <= '0;
            cnt_q        <= '0;
            sclk         <= 1'b0;
            cs           <= 1'b1;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= shift_en && (cnt_q == 4'd9);
            // divider only runs inside a frame
            if (state_q == idle || tick) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            case (state_q)
                idle: begin
                    if (sample_en) begin
                        state_q <= shift;
                        cs      <= 1'b0;
                        cnt_q   <= '0;
                    end
                end
                shift: begin
                    if (tick) begin
                        sclk <= !sclk;
                        // falling edge closes a bit period
                        if (sclk && cnt_q == 4'd9) begin
                            state_q <= gap;
                            cs      <= 1'b1;
                            cnt_q   <= '0;
                        end else if (sclk) begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                gap: begin
                    // cs high for two serial periods
                    if (tick && cnt_q == 4'd3) begin
                        cnt_q   <= '0;
                        state_q <= sample_en ? shift : idle;
                        cs      <= !sample_en;
                    end else if (tick) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= idle;
            endcase
        end
    end

    // msb first, all channels in lockstep
    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = 0; i < CHANNELS; i++) begin
                shift_q.ch[i] <= {shift_q.ch[i][$bits(sample_t)-2:0], sdata[i]};
            end
        end
    end

endmodule

`default_nettype wire

/* source/command_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module command_reader #(
    parameter int DEPTH = 64
) (
    input  logic                clk,
    input  logic                reset_b,
    input  acq_pkg::byte_t      rx_data,
    input  logic                rx_ready,
    input  logic                tx_ready,
    input  acq_pkg::sample_t    peak_value,
    input  acq_pkg::sample_t    rd_data,
    input  acq_pkg::status_t    status,
    output acq_pkg::byte_t      tx_data,
    output logic                tx_en,
    output logic                sample_en,
    output acq_pkg::chan_t      peak_sel,
    output logic                peak_clear,
    output acq_pkg::trig_cfg_t  trig_cfg,
    output logic                rd_req
);
    import acq_pkg::*;

    // longest reply is the dump, head plus two bytes per sample
    localparam int CNT_W = $clog2(2 * DEPTH + 2);

    typedef enum logic [2:0] {idle, thresh_hi, thresh_lo, send, wait_ready} cmd_state_t;

    cmd_state_t        state_q;
    // reply bytes still to send
    logic [CNT_W-1:0]  cnt_q;
    // next byte is byte_q, not part of a sample pair
    logic              byte_pend_q;
    // pairs come from the peak cache, else from the ring buffer
    logic              peak_q;
    byte_t             byte_q;
    sample_t           word_q;
    sample_t           word;
    logic              is_peak;

    assign word    = peak_q ? peak_value : rd_data;
    assign is_peak = (rx_data[7:4] == OP_PEAK[7:4]) && (rx_data[3:0] < CHANNELS);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state_q     <= idle;
            cnt_q       <= '0;
            byte_pend_q <= 1'b0;
            peak_q      <= 1'b0;
            byte_q      <= '0;
            word_q      <= '0;
            tx_data     <= '0;
            tx_en       <= 1'b0;
            sample_en   <= 1'b0;
            peak_sel    <= '0;
            peak_clear  <= 1'b0;
            trig_cfg    <= '0;
            rd_req      <= 1'b0;
        end else begin
            // strobes last one cycle
            tx_en        <= 1'b0;
            peak_clear   <= 1'b0;
            rd_req       <= 1'b0;
            trig_cfg.arm <= 1'b0;
            case (state_q)
                idle: begin
                    if (rx_ready) begin
                        // most commands answer with one byte
                        state_q     <= send;
                        cnt_q       <= CNT_W'(1);
                        byte_pend_q <= 1'b1;
                        peak_q      <= 1'b0;
                        if (is_peak) begin
                            cnt_q       <= CNT_W'(2);
                            byte_pend_q <= 1'b0;
                            peak_q      <= 1'b1;
                            peak_sel    <= chan_t'(rx_data[3:0]);
                        end else if (rx_data == OP_THRESH) begin
                            state_q <= thresh_hi;
                        end else if (rx_data == OP_DUMP && status.frozen) begin
                            byte_q <= REPLY_DUMP_HEAD;
                            cnt_q  <= CNT_W'(2 * DEPTH + 1);
                        end else if (rx_data == OP_STATUS) begin
                            byte_q <= byte_t'(status);
                        end else if (rx_data == OP_START || rx_data == OP_STOP) begin
                            sample_en <= (rx_data == OP_START);
                            state_q   <= idle;
                        end else begin
                            byte_q <= REPLY_ERR;
                        end
                    end
                end
                thresh_hi: begin
                    if (rx_ready) begin
                        trig_cfg.threshold <= sample_t'({rx_data, 8'h00});
                        state_q            <= thresh_lo;
                    end
                end
                thresh_lo: begin
                    // low byte completes the threshold and arms
                    if (rx_ready) begin
                        trig_cfg.threshold[7:0] <= rx_data;
                        trig_cfg.arm            <= 1'b1;
                        state_q                 <= idle;
                    end
                end
                send: begin
                    if (tx_ready) begin
                        tx_en   <= 1'b1;
                        cnt_q   <= cnt_q - 1'b1;
                        state_q <= wait_ready;
                        if (byte_pend_q) begin
                            tx_data     <= byte_q;
                            byte_pend_q <= 1'b0;
                        end else if (!cnt_q[0]) begin
                            // high byte, keep the whole word for the low byte
                            tx_data    <= byte_t'(word >> 8);
                            word_q     <= word;
                            peak_clear <= peak_q;
                        end else begin
                            tx_data <= word_q[7:0];
                        end
                        // dump fetches the next sample during the wait cycle
                        if (!peak_q && cnt_q[0] && cnt_q != CNT_W'(1)) begin
                            rd_req <= 1'b1;
                        end
                    end
                end
                wait_ready: begin
                    // tx_ready is only valid again from the next cycle
                    state_q <= (cnt_q == '0) ? idle : send;
                end
                default: state_q <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/level_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module level_trigger (
    input  logic                  clk,
    input  logic                  reset_b,
    input  acq_pkg::sample_set_t  samples,
    input  logic                  sample_valid,
    input  acq_pkg::trig_cfg_t    trig_cfg,
    output logic                  trigger,
    output logic                  armed,
    output logic                  triggered
);
    import acq_pkg::*;

    sample_t thresh_q;
    logic    hit;

    // channel 0 strictly above threshold while armed
    assign hit = armed && sample_valid && (samples.ch[0] > thresh_q);

    // threshold only changes together with an arm
    always_ff @(posedge clk) begin
        if (trig_cfg.arm) begin
            thresh_q <= trig_cfg.threshold;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            trigger   <= 1'b0;
            armed     <= 1'b0;
            triggered <= 1'b0;
        end else if (trig_cfg.arm) begin
            // rearm drops any previous trigger
            trigger   <= 1'b0;
            armed     <= 1'b1;
            triggered <= 1'b0;
        end else begin
            // single pulse, then disarmed
            trigger <= hit;
            if (hit) begin
                armed     <= 1'b0;
                triggered <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/peak_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module peak_cache (
    input  logic                  clk,
    input  logic                  reset_b,
    input  acq_pkg::sample_set_t  samples,
    input  logic                  sample_valid,
    input  acq_pkg::chan_t        peak_sel,
    input  logic                  peak_clear,
    output acq_pkg::sample_t      peak_value
);
    import acq_pkg::*;

    // running maximum per channel
    sample_t peak_q [CHANNELS];

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            for (int i = 0; i < CHANNELS; i++) begin
                peak_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CHANNELS; i++) begin
                // clear restarts from the frame arriving now, if any
                if (peak_clear && peak_sel == chan_t'(i)) begin
                    peak_q[i] <= sample_valid ? samples.ch[i] : '0;
                end else if (sample_valid && samples.ch[i] > peak_q[i]) begin
                    peak_q[i] <= samples.ch[i];
                end
            end
        end
    end

    // read mux, no register stage
    assign peak_value = peak_q[peak_sel];

endmodule

`default_nettype wire

/* source/ring_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module ring_buffer #(
    parameter int DEPTH = 64,
    parameter int POST  = 32
) (
    input  logic                  clk,
    input  logic                  reset_b,
    input  acq_pkg::sample_set_t  samples,
    input  logic                  sample_valid,
    input  logic                  trigger,
    input  logic                  arm,
    input  logic                  rd_req,
    output logic                  frozen,
    output acq_pkg::sample_t      rd_data
);
    import acq_pkg::*;

    // pointers wrap, so DEPTH is a power of two
    localparam int AW = $clog2(DEPTH);
    localparam int PW = $clog2(POST + 1);

    sample_t        mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    // samples still to write after the trigger
    logic [PW-1:0]  post_cnt;
    logic           post_run;
    logic           wr_en;
    logic           freeze;

    assign wr_en  = sample_valid && !frozen;
    // last post trigger sample goes in this cycle
    assign freeze = wr_en && post_run && !arm && (post_cnt == PW'(1));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= samples.ch[0];
        end
        if (rd_req) begin
            rd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            post_cnt <= '0;
            post_run <= 1'b0;
            frozen   <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (arm) begin
                post_cnt <= '0;
                post_run <= 1'b0;
                frozen   <= 1'b0;
            end else if (trigger && !frozen) begin
                post_cnt <= PW'(POST);
                post_run <= 1'b1;
            end else if (freeze) begin
                post_run <= 1'b0;
                frozen   <= 1'b1;
            end else if (wr_en && post_run) begin
                post_cnt <= post_cnt - 1'b1;
            end
            // readout starts at the oldest entry, next slot to be written
            if (freeze) begin
                rd_ptr <= wr_ptr + 1'b1;
            end else if (rd_req) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
